/* src/board_regs_pkg.sv */
package board_regs_pkg;

  // --------------------------------------------------
  // register bus types
  // --------------------------------------------------

  // register address from the spi command byte
  typedef logic [6:0] reg_addr_t;
  // one register byte
  typedef logic [7:0] reg_data_t;
  // route source select for one serial output
  typedef logic [2:0] route_sel_t;
  // one bit per regulator
  typedef logic [3:0] reg_en_t;

  // --------------------------------------------------
  // register map
  // --------------------------------------------------
  localparam reg_addr_t addr_magic      = 7'd0;
  localparam reg_addr_t addr_version    = 7'd1;
  localparam reg_addr_t addr_switches   = 7'd2;
  localparam reg_addr_t addr_config     = 7'd3;
  localparam reg_addr_t addr_asic_cntl  = 7'd4;
  localparam reg_addr_t addr_regs       = 7'd5;
  // four tacho counters from here
  localparam reg_addr_t addr_tacho_base = 7'd12;
  // seven route selectors from here
  localparam reg_addr_t addr_route_base = 7'd16;
  localparam reg_addr_t addr_sticky     = 7'd30;

  // routed outputs uc, down, up, die 0 to 3
  localparam int route_count = 7;

  // fixed read values and reset defaults
  localparam reg_data_t magic_value = 8'hb4;
  localparam reg_data_t version_value = 8'd1;
  localparam logic default_pll_bypass = 1'b1;
  localparam logic [2:0] default_baud_rate = 3'd0;

endpackage

/* src/board_timing_pkg.sv */
package board_timing_pkg;

  // --------------------------------------------------
  // tick chain and tacho sizes
  // --------------------------------------------------

  // tenth of a second at 8 MHz, doubled when clk16 is set
  localparam int ten_hz_cycles_8m = 800000;
  // ten_hz pulses per one_hz pulse
  localparam int tenths_per_second = 10;

  // tacho pulses per second, saturating
  typedef logic [7:0] tacho_count_t;

endpackage

/* src/spi_slave.sv */
module spi_slave (
  input  logic                      fclk,
  input  logic                      reset,
  input  logic                      spi_clk,
  input  logic                      spi_en_bar,
  input  logic                      spi_din,
  output logic                      spi_dout,
  output logic                      spi_dout_en,
  output board_regs_pkg::reg_addr_t reg_addr,
  output board_regs_pkg::reg_data_t reg_wd,
  output logic                      reg_we,
  output logic                      reg_re,
  input  board_regs_pkg::reg_data_t reg_rd
);

  // two sync flops plus one history flop for edge detect
  logic [2:0] clk_s;
  logic [1:0] en_bar_s;
  logic [1:0] din_s;
  logic clk_rise;
  logic clk_fall;
  // bit position in the 16 bit frame
  logic [3:0] bit_cnt;
  logic rw;
  // reg_rd is valid the cycle after reg_re
  logic load_rd;
  // last seven bits received
  logic [6:0] rx_shift;
  board_regs_pkg::reg_data_t tx_shift;

  // edges only count while selected
  assign clk_rise = clk_s[1] & ~clk_s[2] & ~en_bar_s[1];
  assign clk_fall = ~clk_s[1] & clk_s[2] & ~en_bar_s[1];
  assign spi_dout_en = ~en_bar_s[1];

  // --------------------------------------------------
  // pin synchronizers
  // --------------------------------------------------
  always_ff @(posedge fclk or negedge reset)
  begin
    if (!reset)
    begin
      clk_s <= '0;
      // idle deselected
      en_bar_s <= '1;
      din_s <= '0;
    end
    else
    begin
      clk_s <= {clk_s[1:0], spi_clk};
      en_bar_s <= {en_bar_s[0], spi_en_bar};
      din_s <= {din_s[0], spi_din};
    end
  end

  // --------------------------------------------------
  // frame shifter and register strobes
  // --------------------------------------------------
  always_ff @(posedge fclk or negedge reset)
  begin
    if (!reset)
    begin
      bit_cnt <= '0;
      rw <= 1'b0;
      rx_shift <= '0;
      tx_shift <= '0;
      spi_dout <= 1'b0;
      reg_addr <= '0;
      reg_wd <= '0;
      reg_we <= 1'b0;
      reg_re <= 1'b0;
      load_rd <= 1'b0;
    end
    else
    begin
      // strobes are single cycle
      reg_we <= 1'b0;
      reg_re <= 1'b0;
      load_rd <= reg_re;
      if (en_bar_s[1])
      begin
        // deselect aborts the frame
        bit_cnt <= '0;
        tx_shift <= '0;
      end
      else
      begin
        if (clk_rise)
        begin
          // msb first on rising spi_clk
          rx_shift <= {rx_shift[5:0], din_s[1]};
          bit_cnt <= bit_cnt + 4'd1;
          // end of command byte with rw at the top
          if (bit_cnt == 4'd7)
          begin
            rw <= rx_shift[6];
            reg_addr <= {rx_shift[5:0], din_s[1]};
            reg_re <= rx_shift[6];
          end
          // end of data byte
          if (bit_cnt == 4'd15)
          begin
            reg_wd <= {rx_shift[6:0], din_s[1]};
            reg_we <= ~rw;
          end
        end
        if (load_rd)
          tx_shift <= reg_rd;
        else if (clk_fall)
        begin
          // next bit out on falling spi_clk
          spi_dout <= tx_shift[7];
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

endmodule

/* src/control_regs.sv */
module control_regs (
  input  logic                           fclk,
  input  logic                           reset,
  input  board_regs_pkg::reg_addr_t      reg_addr,
  input  board_regs_pkg::reg_data_t      reg_wd,
  input  logic                           reg_we,
  input  logic                           reg_re,
  input  board_regs_pkg::reg_data_t      route_rd,
  output board_regs_pkg::reg_data_t      reg_rd,
  input  board_regs_pkg::reg_data_t      config_sw,
  input  board_regs_pkg::reg_en_t        pgood,
  input  board_timing_pkg::tacho_count_t tach0,
  input  board_timing_pkg::tacho_count_t tach1,
  input  board_timing_pkg::tacho_count_t tach2,
  input  board_timing_pkg::tacho_count_t tach3,
  output logic                           clk16,
  output board_regs_pkg::reg_en_t        reg_en,
  output logic                           asic_reset_n,
  output logic                           pll_bypass,
  output logic [2:0]                     baud_rate
);

  // stored only, read back through config
  logic big_endian;
  board_regs_pkg::reg_en_t sticky;
  // pgood synchronizer and history for fall detect
  board_regs_pkg::reg_en_t pgood_meta;
  board_regs_pkg::reg_en_t pgood_sync;
  board_regs_pkg::reg_en_t pgood_last;
  board_regs_pkg::reg_en_t pgood_fall;
  board_regs_pkg::reg_data_t read_data;

  assign pgood_fall = pgood_last & ~pgood_sync;

  // --------------------------------------------------
  // writable registers and sticky power-good
  // --------------------------------------------------
  always_ff @(posedge fclk or negedge reset)
  begin
    if (!reset)
    begin
      clk16 <= 1'b0;
      big_endian <= 1'b0;
      asic_reset_n <= 1'b0;
      pll_bypass <= board_regs_pkg::default_pll_bypass;
      baud_rate <= board_regs_pkg::default_baud_rate;
      reg_en <= '0;
      sticky <= '0;
      pgood_meta <= '0;
      pgood_sync <= '0;
      pgood_last <= '0;
    end
    else
    begin
      pgood_meta <= pgood;
      pgood_sync <= pgood_meta;
      pgood_last <= pgood_sync;
      if (reg_we && reg_addr == board_regs_pkg::addr_config)
        {big_endian, clk16} <= reg_wd[1:0];
      if (reg_we && reg_addr == board_regs_pkg::addr_asic_cntl)
        {asic_reset_n, pll_bypass, baud_rate} <= reg_wd[4:0];
      if (reg_we && reg_addr == board_regs_pkg::addr_regs)
        reg_en <= reg_wd[3:0];
      // write loads, read rearms from reg_en, else falls clear
      if (reg_we && reg_addr == board_regs_pkg::addr_regs)
        sticky <= reg_wd[3:0];
      else if (reg_re && reg_addr == board_regs_pkg::addr_sticky)
        sticky <= reg_en;
      else
        sticky <= sticky & ~pgood_fall;
    end
  end

  // --------------------------------------------------
  // read mux
  // --------------------------------------------------
  always_comb
  begin
    case (reg_addr)
      board_regs_pkg::addr_magic: read_data = board_regs_pkg::magic_value;
      board_regs_pkg::addr_version: read_data = board_regs_pkg::version_value;
      board_regs_pkg::addr_switches: read_data = config_sw;
      board_regs_pkg::addr_config: read_data = {6'b0, big_endian, clk16};
      board_regs_pkg::addr_asic_cntl:
        read_data = {3'b0, asic_reset_n, pll_bypass, baud_rate};
      // status, pgood high nibble
      board_regs_pkg::addr_regs: read_data = {pgood_sync, reg_en};
      board_regs_pkg::addr_tacho_base: read_data = tach0;
      board_regs_pkg::addr_tacho_base + 7'd1: read_data = tach1;
      board_regs_pkg::addr_tacho_base + 7'd2: read_data = tach2;
      board_regs_pkg::addr_tacho_base + 7'd3: read_data = tach3;
      board_regs_pkg::addr_sticky: read_data = {4'b0, sticky};
      // router gives zero outside its block
      default: read_data = route_rd;
    endcase
  end

  // captured on the read strobe, held for the slave
  always_ff @(posedge fclk)
  begin
    if (reg_re)
      reg_rd <= read_data;
  end

endmodule

/* src/serial_router.sv */
module serial_router (
  input  logic                      fclk,
  input  logic                      reset,
  input  board_regs_pkg::reg_addr_t reg_addr,
  input  board_regs_pkg::reg_data_t reg_wd,
  input  logic                      reg_we,
  output board_regs_pkg::reg_data_t route_rd,
  input  logic                      sin_uc,
  input  logic                      sin_up,
  input  logic                      sin_down,
  input  logic [3:0]                sin,
  output logic                      sout_uc,
  output logic                      sout_up,
  output logic                      sout_down,
  output logic [3:0]                sout
);

  board_regs_pkg::route_sel_t route_sel [board_regs_pkg::route_count];
  // source 0 is idle high
  logic [7:0] sources;
  logic [board_regs_pkg::route_count-1:0] routed;
  logic in_block;
  logic [2:0] route_idx;

  assign in_block = (reg_addr >= board_regs_pkg::addr_route_base) &&
                    (reg_addr < board_regs_pkg::addr_route_base + board_regs_pkg::route_count);
  assign route_idx = 3'(reg_addr - board_regs_pkg::addr_route_base);
  assign route_rd = in_block ? {5'b0, route_sel[route_idx]} : '0;

  // --------------------------------------------------
  // route selectors
  // --------------------------------------------------
  always_ff @(posedge fclk or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < board_regs_pkg::route_count; i++)
        route_sel[i] <= '0;
    end
    else if (reg_we && in_block)
      route_sel[route_idx] <= reg_wd[2:0];
  end

  // --------------------------------------------------
  // matrix, purely combinational
  // --------------------------------------------------
  assign sources = {sin, sin_up, sin_down, sin_uc, 1'b1};

  for (genvar i = 0; i < board_regs_pkg::route_count; i++)
  begin : g_route
    assign routed[i] = sources[route_sel[i]];
  end

  // output order uc, down, up, die 0 to 3
  assign {sout, sout_up, sout_down, sout_uc} = routed;

endmodule

/* src/tick_gen.sv */
module tick_gen #(
  parameter int ticks_per_tenth = board_timing_pkg::ten_hz_cycles_8m
) (
  input  logic fclk,
  input  logic reset,
  input  logic clk16,
  output logic one_hz
);

  // wide enough for the doubled count
  localparam int cnt_w = $clog2(2 * ticks_per_tenth);

  logic [cnt_w-1:0] ten_cnt;
  logic [cnt_w-1:0] ten_last;
  logic ten_hz;
  // ten_hz pulses in the current second
  logic [3:0] tenth_cnt;

  // twice the count with a 16 MHz clock
  assign ten_last = clk16 ? cnt_w'(2 * ticks_per_tenth - 1) : cnt_w'(ticks_per_tenth - 1);

  // --------------------------------------------------
  // ten_hz and one_hz pulses
  // --------------------------------------------------
  always_ff @(posedge fclk or negedge reset)
  begin
    if (!reset)
    begin
      ten_cnt <= '0;
      ten_hz <= 1'b0;
      tenth_cnt <= '0;
      one_hz <= 1'b0;
    end
    else
    begin
      // >= covers a clk16 drop mid count
      ten_hz <= (ten_cnt >= ten_last);
      ten_cnt <= (ten_cnt >= ten_last) ? '0 : ten_cnt + 1'b1;
      one_hz <= 1'b0;
      if (ten_hz)
      begin
        if (tenth_cnt == 4'(board_timing_pkg::tenths_per_second - 1))
        begin
          tenth_cnt <= '0;
          one_hz <= 1'b1;
        end
        else
          tenth_cnt <= tenth_cnt + 4'd1;
      end
    end
  end

endmodule

/* src/tacho_timer.sv */
module tacho_timer (
  input  logic                           fclk,
  input  logic                           reset,
  input  logic                           one_hz,
  input  logic                           tacho,
  output board_timing_pkg::tacho_count_t pulses_per_second
);

  // two sync flops plus history
  logic [2:0] tacho_s;
  logic tacho_rise;
  board_timing_pkg::tacho_count_t edge_cnt;

  assign tacho_rise = tacho_s[1] & ~tacho_s[2];

  always_ff @(posedge fclk or negedge reset)
  begin
    if (!reset)
    begin
      tacho_s <= '0;
      edge_cnt <= '0;
      pulses_per_second <= '0;
    end
    else
    begin
      tacho_s <= {tacho_s[1:0], tacho};
      if (one_hz)
      begin
        // latch and restart, keeping a coincident edge
        pulses_per_second <= edge_cnt;
        edge_cnt <= tacho_rise ? 8'd1 : 8'd0;
      end
      // saturate at 255
      else if (tacho_rise && edge_cnt != '1)
        edge_cnt <= edge_cnt + 8'd1;
    end
  end

endmodule

/* src/board_ctrl.sv */
module board_ctrl #(
  parameter int ticks_per_tenth = board_timing_pkg::ten_hz_cycles_8m
) (
  input  logic       fclk,
  input  logic       reset,
  // regulators
  input  logic [3:0] pgood,
  output logic [3:0] reg_en,
  // serial links
  input  logic       sin_uc,
  input  logic       sin_up,
  input  logic       sin_down,
  input  logic [3:0] sin,
  output logic       sout_uc,
  output logic       sout_up,
  output logic       sout_down,
  output logic [3:0] sout,
  // asic mode pins
  output logic       pll_bypass,
  output logic       asic_reset_n,
  output logic [2:0] baud_rate,
  // spi slave to the microcontroller
  input  logic       spi_clk,
  input  logic       spi_en_bar,
  input  logic       spi_din,
  output logic       spi_dout,
  output logic       spi_dout_en,
  // misc inputs
  input  logic [7:0] config_sw,
  input  logic [3:0] tacho
);

  board_regs_pkg::reg_addr_t reg_addr;
  board_regs_pkg::reg_data_t reg_wd;
  board_regs_pkg::reg_data_t reg_rd;
  board_regs_pkg::reg_data_t route_rd;
  logic reg_we;
  logic reg_re;
  logic clk16;
  logic one_hz;
  board_timing_pkg::tacho_count_t tach [4];

  // --------------------------------------------------
  // register bus
  // --------------------------------------------------
  spi_slave spi_slave_inst (
    .fclk(fclk), .reset(reset),
    .spi_clk(spi_clk), .spi_en_bar(spi_en_bar), .spi_din(spi_din),
    .spi_dout(spi_dout), .spi_dout_en(spi_dout_en),
    .reg_addr(reg_addr), .reg_wd(reg_wd), .reg_we(reg_we), .reg_re(reg_re),
    .reg_rd(reg_rd)
  );

  control_regs control_regs_inst (
    .fclk(fclk), .reset(reset),
    .reg_addr(reg_addr), .reg_wd(reg_wd), .reg_we(reg_we), .reg_re(reg_re),
    .route_rd(route_rd), .reg_rd(reg_rd), .config_sw(config_sw), .pgood(pgood),
    .tach0(tach[0]), .tach1(tach[1]), .tach2(tach[2]), .tach3(tach[3]),
    .clk16(clk16), .reg_en(reg_en), .asic_reset_n(asic_reset_n),
    .pll_bypass(pll_bypass), .baud_rate(baud_rate)
  );

  serial_router serial_router_inst (
    .fclk(fclk), .reset(reset),
    .reg_addr(reg_addr), .reg_wd(reg_wd), .reg_we(reg_we), .route_rd(route_rd),
    .sin_uc(sin_uc), .sin_up(sin_up), .sin_down(sin_down), .sin(sin),
    .sout_uc(sout_uc), .sout_up(sout_up), .sout_down(sout_down), .sout(sout)
  );

  // --------------------------------------------------
  // tick chain and fan tachos
  // --------------------------------------------------
  tick_gen #(.ticks_per_tenth(ticks_per_tenth)) tick_gen_inst (
    .fclk(fclk), .reset(reset), .clk16(clk16), .one_hz(one_hz)
  );

  for (genvar i = 0; i < 4; i++)
  begin : g_tacho
    tacho_timer tacho_timer_inst (
      .fclk(fclk), .reset(reset), .one_hz(one_hz),
      .tacho(tacho[i]), .pulses_per_second(tach[i])
    );
  end

endmodule

/* bench/clock_gen.sv */
module clock_gen (
  output logic fclk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial
  begin
    fclk = 1'b0;
    forever #20 fclk = ~fclk;
  end

  // reset held low for three cycles, released on a falling edge
  initial
  begin
    reset = 1'b0;
    repeat (3) @(posedge fclk);
    @(negedge fclk);
    reset = 1'b1;
  end

endmodule

/* bench/board_ctrl_asserts.sv */
module board_ctrl_asserts (
  input logic fclk,
  input logic reset,
  input logic reg_we,
  input logic reg_re,
  input logic spi_en_bar,
  input logic spi_dout_en,
  input logic one_hz
);

  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // register bus strobes
  // --------------------------------------------------
  strobe_exclusive: assert property (@(posedge fclk) disable iff (!reset)
    !(reg_we && reg_re))
    else $error("reg_we and reg_re high together");

  // output enable lags the select pin by the two sync flops
  dout_en_follows: assert property (@(posedge fclk) disable iff (!reset)
    spi_dout_en == !$past(spi_en_bar, 2))
    else $error("spi_dout_en does not follow spi_en_bar");

  // --------------------------------------------------
  // tick chain
  // --------------------------------------------------
  one_hz_single: assert property (@(posedge fclk) disable iff (!reset)
    one_hz |=> !one_hz)
    else $error("one_hz longer than one cycle");

endmodule

bind board_ctrl board_ctrl_asserts asserts_inst (
  .fclk(fclk),
  .reset(reset),
  .reg_we(reg_we),
  .reg_re(reg_re),
  .spi_en_bar(spi_en_bar),
  .spi_dout_en(spi_dout_en),
  .one_hz(one_hz)
);

/* bench/board_ctrl_tb.sv */
module board_ctrl_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ticks = 50;
  localparam int max_tests = 64;
  // 4 idle and 8 closing around 16 bits of 8 cycles
  localparam int frame_cycles = 140;

  logic fclk;
  logic reset;
  logic [3:0] pgood;
  logic [3:0] reg_en;
  logic sin_uc;
  logic sin_up;
  logic sin_down;
  logic [3:0] sin;
  logic sout_uc;
  logic sout_up;
  logic sout_down;
  logic [3:0] sout;
  logic pll_bypass;
  logic asic_reset_n;
  logic [2:0] baud_rate;
  logic spi_clk;
  logic spi_en_bar;
  logic spi_din;
  logic spi_dout;
  logic spi_dout_en;
  logic [7:0] config_sw;
  logic [3:0] tacho;

  // test table from the data file
  byte ops [max_tests];
  int args [max_tests][8];
  int n_tests;
  int errors;
  int checks;
  int cycles;
  int limit;
  // clk16 as last written to config
  bit clk16_shadow;
  // route selectors as last written
  int route_shadow [board_regs_pkg::route_count];
  int tach_period [4];
  int tach_phase [4];

  clock_gen clock_gen_inst (.fclk(fclk), .reset(reset));

  board_ctrl #(.ticks_per_tenth(ticks)) board_ctrl_inst (
    .fclk(fclk), .reset(reset), .pgood(pgood), .reg_en(reg_en),
    .sin_uc(sin_uc), .sin_up(sin_up), .sin_down(sin_down), .sin(sin),
    .sout_uc(sout_uc), .sout_up(sout_up), .sout_down(sout_down), .sout(sout),
    .pll_bypass(pll_bypass), .asic_reset_n(asic_reset_n), .baud_rate(baud_rate),
    .spi_clk(spi_clk), .spi_en_bar(spi_en_bar), .spi_din(spi_din),
    .spi_dout(spi_dout), .spi_dout_en(spi_dout_en),
    .config_sw(config_sw), .tacho(tacho)
  );

  // --------------------------------------------------
  // checks and timeout
  // --------------------------------------------------
  task automatic check_value(input string what, input int got, input int exp, input int tol);
    int diff;
    begin
      diff = (got > exp) ? got - exp : exp - got;
      checks++;
      if (diff > tol)
      begin
        errors++;
        $display("FAIL %0t %s: got %0h expected %0h", $time, what, got, exp);
      end
    end
  endtask

  always @(posedge fclk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout: run did not end within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  // fan tachos half high and half low per period
  always @(negedge fclk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (tach_period[i] == 0)
      begin
        tach_phase[i] = 0;
        tacho[i] = 1'b0;
      end
      else
      begin
        tach_phase[i] = (tach_phase[i] + 1) % tach_period[i];
        tacho[i] = (tach_phase[i] < tach_period[i] / 2);
      end
    end
  end

  // --------------------------------------------------
  // spi master in mode 0 with 4 cycle half periods
  // --------------------------------------------------
  task automatic spi_frame(input bit sel, input logic [7:0] cmd, input logic [7:0] wd,
                           output logic [7:0] rd);
    begin
      rd = '0;
      spi_en_bar = !sel;
      repeat (4) @(negedge fclk);
      for (int i = 0; i < 16; i++)
      begin
        spi_din = (i < 8) ? cmd[7-i] : wd[15-i];
        repeat (4) @(negedge fclk);
        // master samples just before its rising edge
        if (i >= 8)
          rd[15-i] = spi_dout;
        if (!sel)
          check_value("spi_dout_en while deselected", spi_dout_en, 0, 0);
        spi_clk = 1'b1;
        repeat (4) @(negedge fclk);
        spi_clk = 1'b0;
      end
      repeat (4) @(negedge fclk);
      spi_en_bar = 1'b1;
      spi_din = 1'b0;
      repeat (4) @(negedge fclk);
    end
  endtask

  task automatic reg_write(input int addr, input int data);
    logic [7:0] unused;
    begin
      spi_frame(1'b1, {1'b0, 7'(addr)}, 8'(data), unused);
      if (addr == 3)
        clk16_shadow = data[0];
      if (addr >= board_regs_pkg::addr_route_base &&
          addr < board_regs_pkg::addr_route_base + board_regs_pkg::route_count)
        route_shadow[addr - board_regs_pkg::addr_route_base] = data & 7;
    end
  endtask

  task automatic reg_read(input int addr, output logic [7:0] rd);
    begin
      spi_frame(1'b1, {1'b1, 7'(addr)}, 8'h00, rd);
    end
  endtask

  // expected routed value from the source numbering
  function automatic logic route_source(input int sel);
    begin
      case (sel)
        0: route_source = 1'b1;
        1: route_source = sin_uc;
        2: route_source = sin_down;
        3: route_source = sin_up;
        default: route_source = sin[sel-4];
      endcase
    end
  endfunction

  task automatic check_route(input int out, input int sel, input int n);
    logic [6:0] outs;
    int exp_sel;
    begin
      for (int k = 0; k < n; k++)
      begin
        {sin, sin_up, sin_down, sin_uc} = 7'($urandom);
        @(posedge fclk);
        outs = {sout, sout_up, sout_down, sout_uc};
        // the named output uses the selector from the test line
        for (int o = 0; o < board_regs_pkg::route_count; o++)
        begin
          exp_sel = (o == out) ? sel : route_shadow[o];
          check_value($sformatf("sout %0d", o), outs[o], route_source(exp_sel), 0);
        end
        @(negedge fclk);
      end
    end
  endtask

  task automatic check_tachos(input int t);
    logic [7:0] rd;
    int second;
    begin
      for (int i = 0; i < 4; i++)
        tach_period[i] = args[t][i];
      second = 10 * ticks * (clk16_shadow ? 2 : 1);
      // one full second after the change before the latch counts
      repeat (2 * second + 20) @(negedge fclk);
      for (int i = 0; i < 4; i++)
      begin
        reg_read(12 + i, rd);
        check_value($sformatf("tacho %0d", i), rd, args[t][4+i], 1);
      end
    end
  endtask

  // --------------------------------------------------
  // test table
  // --------------------------------------------------
  task automatic load_tests();
    int fd;
    int code;
    string line;
    byte op;
    begin
      n_tests = 0;
      fd = $fopen("bench/board_ctrl_tests.txt", "r");
      if (fd == 0)
      begin
        $display("cannot open bench/board_ctrl_tests.txt");
        errors++;
      end
      else
      begin
        while (!$feof(fd) && n_tests < max_tests)
        begin
          code = $fgets(line, fd);
          if (code > 1 && line.getc(0) != "#")
          begin
            op = line.getc(0);
            for (int k = 0; k < 8; k++)
              args[n_tests][k] = 0;
            code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h",
                           args[n_tests][0], args[n_tests][1], args[n_tests][2],
                           args[n_tests][3], args[n_tests][4], args[n_tests][5],
                           args[n_tests][6], args[n_tests][7]);
            ops[n_tests] = op;
            n_tests++;
          end
        end
        $fclose(fd);
      end
    end
  endtask

  // rough cycle cost of each op with clk16 set
  function automatic int test_cycles();
    int sum;
    begin
      sum = 20;
      for (int t = 0; t < n_tests; t++)
        case (ops[t])
          "W", "R", "N": sum += frame_cycles;
          "S": sum += 2 * args[t][2];
          "D": sum += args[t][0];
          "T": sum += 2 * 10 * ticks * 2 + 20 + 4 * frame_cycles;
          default: sum += 2;
        endcase
      test_cycles = sum;
    end
  endfunction

  initial
  begin
    logic [7:0] rd;
    pgood = 4'hf;
    {sin, sin_up, sin_down, sin_uc} = '0;
    spi_clk = 1'b0;
    spi_en_bar = 1'b1;
    spi_din = 1'b0;
    config_sw = '0;
    tacho = '0;
    errors = 0;
    checks = 0;
    cycles = 0;
    limit = 0;
    clk16_shadow = 1'b0;
    for (int i = 0; i < board_regs_pkg::route_count; i++)
      route_shadow[i] = 0;
    for (int i = 0; i < 4; i++)
    begin
      tach_period[i] = 0;
      tach_phase[i] = 0;
    end
    void'($urandom(32'h4ee4b06e));
    load_tests();
    limit = 2 * test_cycles();
    @(posedge reset);
    repeat (2) @(negedge fclk);

    for (int t = 0; t < n_tests; t++)
    begin
      case (ops[t])
        "W": reg_write(args[t][0], args[t][1]);
        "R":
        begin
          reg_read(args[t][0], rd);
          check_value($sformatf("read addr %0h", args[t][0]), rd, args[t][1], 0);
        end
        "P":
        begin
          config_sw = 8'(args[t][0]);
          pgood = 4'(args[t][1]);
          @(negedge fclk);
        end
        "C":
        begin
          check_value("reg_en", reg_en, args[t][0], 0);
          check_value("asic_reset_n", asic_reset_n, args[t][1], 0);
          check_value("pll_bypass", pll_bypass, args[t][2], 0);
          check_value("baud_rate", baud_rate, args[t][3], 0);
        end
        "S": check_route(args[t][0], args[t][1], args[t][2]);
        "T": check_tachos(t);
        // frame with the select pin left high
        "N": spi_frame(1'b0, {1'b0, 7'(args[t][0])}, 8'(args[t][1]), rd);
        "D": repeat (args[t][0]) @(negedge fclk);
        default:
        begin
          $display("unknown op %c in test %0d", ops[t], t);
          errors++;
        end
      endcase
    end

    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0 && n_tests > 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* bench/board_ctrl_tests.txt */
# op then hex values: W addr data, R addr expect, P switches pgood, D cycles
# C reg_en asic_reset_n pll_bypass baud_rate, S out sel count, N addr data
# T period0..period3 expect0..expect3
P 5a f
D 8
R 0 b4
R 1 1
R 2 5a
R 4 08
C 0 0 1 0
W 3 02
R 3 02
W 4 1d
R 4 1d
C 0 1 1 5
W 4 12
C 0 1 0 2
N 3 ff
R 3 02
W 10 1
S 0 1 10
W 11 6
S 1 6 10
W 16 3
S 6 3 10
R 11 06
S 2 0 10
W 5 f
C f 1 0 2
R 1e 0f
P 5a d
D 8
R 5 df
R 1e 0d
R 1e 0f
T a 19 32 0 32 14 a 0
W 3 03
T a 19 32 0 64 28 14 0

/* files.f */
src/board_regs_pkg.sv
src/board_timing_pkg.sv
src/spi_slave.sv
src/control_regs.sv
src/serial_router.sv
src/tick_gen.sv
src/tacho_timer.sv
src/board_ctrl.sv
bench/clock_gen.sv
bench/board_ctrl_asserts.sv
bench/board_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
SEED ?= 1
TOP ?= board_ctrl_tb
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f files.f
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
